// File: rtl/stream_shell_settings.svh
// Stream shell build settings for beat, strobe, timer and heartbeat sizes
`ifndef STREAM_SHELL_SETTINGS_SVH
`define STREAM_SHELL_SETTINGS_SVH

// One streaming beat between the DMA and the core
`define STREAM_DATA_WIDTH 128

// One strobe bit per byte of a beat
`define STREAM_STRB_WIDTH 16

// Timer count and timer register data
`define HW_TIMER_WIDTH 32

// Free-running heartbeat counter, upper four bits drive the indicators
`define HEARTBEAT_WIDTH 7

// Value written into bytes whose strobe is low
// FF decodes as NaN in FP16, so masked bytes stand out in the output
`define MASK_FILL_BYTE 8'hFF

`endif

// File: rtl/stream_types_pkg.sv
// Stream types shared by the ingress and egress stages
`default_nettype none

`include "stream_shell_settings.svh"

package stream_types_pkg;

    // One beat of stream data
    typedef logic [`STREAM_DATA_WIDTH-1:0] stream_beat_t;

    // Byte strobes for one beat
    typedef logic [`STREAM_STRB_WIDTH-1:0] stream_strb_t;

    // Occupancy of a one-beat output register
    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } stage_state_e;

endpackage

`default_nettype wire

// File: rtl/timer_types_pkg.sv
// Timer types shared by the timer register block and the timer counter
`default_nettype none

`include "stream_shell_settings.svh"

package timer_types_pkg;

    // Elapsed cycle count and register data
    typedef logic [`HW_TIMER_WIDTH-1:0] timer_count_t;

    // Command decoded from a register write
    typedef enum logic [1:0] {
        TCMD_NONE  = 2'd0,
        TCMD_START = 2'd1,
        TCMD_STOP  = 2'd2
    } timer_cmd_e;

    // Counter run state
    typedef enum logic {
        TIMER_IDLE = 1'b0,
        TIMER_RUN  = 1'b1
    } timer_state_e;

endpackage

`default_nettype wire

// File: rtl/ingress_byte_swap.sv
// Ingress stage that turns big-endian DMA beats into little-endian core beats
`timescale 1ns/1ps
`default_nettype none

`include "stream_shell_settings.svh"

module ingress_byte_swap (
    input  wire logic                           sys_pll_clk,
    input  wire logic                           global_pll_resetn,

    // From the DMA
    input  wire stream_types_pkg::stream_beat_t i_in_data,
    input  wire logic                           i_in_valid,
    output logic                                o_in_ready,

    // To the core
    output stream_types_pkg::stream_beat_t      o_out_data,
    output logic                                o_out_valid,
    input  wire logic                           i_out_ready
);

    import stream_types_pkg::*;

    stage_state_e state;
    stream_beat_t swapped_data;
    logic         accept;

    // Byte 0 trades places with the last byte, byte 1 with the one before it
    always_comb begin
        for (int i = 0; i < `STREAM_STRB_WIDTH; i++) begin
            swapped_data[i*8 +: 8] = i_in_data[(`STREAM_STRB_WIDTH-1-i)*8 +: 8];
        end
    end

    // Room when empty or when the held beat leaves on this edge
    assign o_in_ready = i_out_ready || (state == STAGE_EMPTY);
    assign accept     = i_in_valid && o_in_ready;

    always_ff @(posedge sys_pll_clk) begin
        if (!global_pll_resetn) begin
            state <= STAGE_EMPTY;
        end else if (accept) begin
            // Covers drain and refill on the same edge
            state <= STAGE_FULL;
        end else if (i_out_ready) begin
            state <= STAGE_EMPTY;
        end
    end

    always_ff @(posedge sys_pll_clk) begin
        if (accept) begin
            o_out_data <= swapped_data;
        end
    end

    assign o_out_valid = (state == STAGE_FULL);

endmodule

`default_nettype wire

// File: rtl/egress_strobe_mask.sv
// Egress stage that fills strobe-disabled bytes before the beat returns to the DMA
`timescale 1ns/1ps
`default_nettype none

`include "stream_shell_settings.svh"

module egress_strobe_mask (
    input  wire logic                           sys_pll_clk,
    input  wire logic                           global_pll_resetn,

    // From the core
    input  wire stream_types_pkg::stream_beat_t i_in_data,
    input  wire stream_types_pkg::stream_strb_t i_in_strb,
    input  wire logic                           i_in_valid,
    output logic                                o_in_ready,

    // To the DMA
    output stream_types_pkg::stream_beat_t      o_out_data,
    output logic                                o_out_valid,
    input  wire logic                           i_out_ready
);

    import stream_types_pkg::*;

    stage_state_e state;
    stream_beat_t masked_data;
    logic         accept;

    // Keep strobed bytes as they are
    always_comb begin
        for (int i = 0; i < `STREAM_STRB_WIDTH; i++) begin
            if (i_in_strb[i]) begin
                masked_data[i*8 +: 8] = i_in_data[i*8 +: 8];
            end else begin
                // Fill byte marks data the core did not write
                masked_data[i*8 +: 8] = `MASK_FILL_BYTE;
            end
        end
    end

    assign o_in_ready = i_out_ready || (state == STAGE_EMPTY);
    assign accept     = i_in_valid && o_in_ready;

    // One-beat holding register
    always_ff @(posedge sys_pll_clk) begin
        if (!global_pll_resetn) begin
            state <= STAGE_EMPTY;
        end else if (accept) begin
            state <= STAGE_FULL;
        end else if (i_out_ready) begin
            state <= STAGE_EMPTY;
        end
    end

    always_ff @(posedge sys_pll_clk) begin
        if (accept) begin
            o_out_data <= masked_data;
        end
    end

    assign o_out_valid = (state == STAGE_FULL);

endmodule

`default_nettype wire

// File: rtl/hw_timer_regs.sv
// Timer register block turning host writes into commands and answering reads
`timescale 1ns/1ps
`default_nettype none

module hw_timer_regs (
    input  wire logic                          sys_pll_clk,
    input  wire logic                          global_pll_resetn,

    // Host register port
    input  wire logic                          i_write,
    input  wire timer_types_pkg::timer_count_t i_writedata,
    input  wire logic                          i_read,
    output timer_types_pkg::timer_count_t      o_readdata,
    output logic                               o_readdatavalid,

    // Counter control and status
    output timer_types_pkg::timer_cmd_e        o_cmd,
    input  wire timer_types_pkg::timer_count_t i_count
);

    import timer_types_pkg::*;

    timer_cmd_e next_cmd;

    // Bit 1 stops, bit 0 starts, stop wins when both are set
    always_comb begin
        next_cmd = TCMD_NONE;
        if (i_write) begin
            if (i_writedata[1]) begin
                next_cmd = TCMD_STOP;
            end else if (i_writedata[0]) begin
                next_cmd = TCMD_START;
            end
        end
    end

    // Command lasts one cycle
    always_ff @(posedge sys_pll_clk) begin
        if (!global_pll_resetn) begin
            o_cmd <= TCMD_NONE;
        end else begin
            o_cmd <= next_cmd;
        end
    end

    // Read answers on the following cycle
    always_ff @(posedge sys_pll_clk) begin
        if (!global_pll_resetn) begin
            o_readdatavalid <= 1'b0;
        end else begin
            o_readdatavalid <= i_read;
        end
    end

    always_ff @(posedge sys_pll_clk) begin
        if (i_read) begin
            o_readdata <= i_count;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hw_timer_counter.sv
// Start/stop counter of elapsed system clock cycles
`timescale 1ns/1ps
`default_nettype none

module hw_timer_counter (
    input  wire logic                          sys_pll_clk,
    input  wire logic                          global_pll_resetn,
    input  wire timer_types_pkg::timer_cmd_e   i_cmd,
    output timer_types_pkg::timer_count_t      o_count
);

    import timer_types_pkg::*;

    timer_state_e state;

    always_ff @(posedge sys_pll_clk) begin
        if (!global_pll_resetn) begin
            state   <= TIMER_IDLE;
            o_count <= '0;
        end else begin
            case (i_cmd)
                TCMD_START: begin
                    // Fresh measurement starts from zero
                    state   <= TIMER_RUN;
                    o_count <= '0;
                end
                TCMD_STOP: begin
                    // Count freezes on the stop edge
                    state <= TIMER_IDLE;
                end
                default: begin
                    if (state == TIMER_RUN) begin
                        o_count <= o_count + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/stream_shell_top.sv
// Streaming shell between the DMA and the accelerator core, with timer and heartbeat
`timescale 1ns/1ps
`default_nettype none

`include "stream_shell_settings.svh"

module stream_shell_top (
    input  wire logic                           sys_pll_clk,
    input  wire logic                           global_pll_resetn,

    // Ingress, DMA to core
    input  wire stream_types_pkg::stream_beat_t i_dma_in_data,
    input  wire logic                           i_dma_in_valid,
    output logic                                o_dma_in_ready,
    output stream_types_pkg::stream_beat_t      o_core_in_data,
    output logic                                o_core_in_valid,
    input  wire logic                           i_core_in_ready,

    // Egress, core to DMA
    input  wire stream_types_pkg::stream_beat_t i_core_out_data,
    input  wire stream_types_pkg::stream_strb_t i_core_out_strb,
    input  wire logic                           i_core_out_valid,
    output logic                                o_core_out_ready,
    output stream_types_pkg::stream_beat_t      o_dma_out_data,
    output logic                                o_dma_out_valid,
    input  wire logic                           i_dma_out_ready,

    // Timer register port
    input  wire logic                           i_timer_write,
    input  wire timer_types_pkg::timer_count_t  i_timer_writedata,
    input  wire logic                           i_timer_read,
    output timer_types_pkg::timer_count_t       o_timer_readdata,
    output logic                                o_timer_readdatavalid,

    // Indicator bits
    output logic [3:0]                          o_heartbeat
);

    import timer_types_pkg::*;

    timer_cmd_e                  timer_cmd;
    timer_count_t                timer_count;
    logic [`HEARTBEAT_WIDTH-1:0] heartbeat_cnt;

    // Big-endian DMA data in, little-endian core data out
    ingress_byte_swap u_ingress (
        .sys_pll_clk       (sys_pll_clk),
        .global_pll_resetn (global_pll_resetn),
        .i_in_data         (i_dma_in_data),
        .i_in_valid        (i_dma_in_valid),
        .o_in_ready        (o_dma_in_ready),
        .o_out_data        (o_core_in_data),
        .o_out_valid       (o_core_in_valid),
        .i_out_ready       (i_core_in_ready)
    );

    egress_strobe_mask u_egress (
        .sys_pll_clk       (sys_pll_clk),
        .global_pll_resetn (global_pll_resetn),
        .i_in_data         (i_core_out_data),
        .i_in_strb         (i_core_out_strb),
        .i_in_valid        (i_core_out_valid),
        .o_in_ready        (o_core_out_ready),
        .o_out_data        (o_dma_out_data),
        .o_out_valid       (o_dma_out_valid),
        .i_out_ready       (i_dma_out_ready)
    );

    // Host infers the clock frequency from this timer
    hw_timer_regs u_timer_regs (
        .sys_pll_clk       (sys_pll_clk),
        .global_pll_resetn (global_pll_resetn),
        .i_write           (i_timer_write),
        .i_writedata       (i_timer_writedata),
        .i_read            (i_timer_read),
        .o_readdata        (o_timer_readdata),
        .o_readdatavalid   (o_timer_readdatavalid),
        .o_cmd             (timer_cmd),
        .i_count           (timer_count)
    );

    hw_timer_counter u_timer_counter (
        .sys_pll_clk       (sys_pll_clk),
        .global_pll_resetn (global_pll_resetn),
        .i_cmd             (timer_cmd),
        .o_count           (timer_count)
    );

    // Free-running sanity counter
    always_ff @(posedge sys_pll_clk) begin
        if (!global_pll_resetn) begin
            heartbeat_cnt <= '0;
        end else begin
            heartbeat_cnt <= heartbeat_cnt + 1'b1;
        end
    end

    // Slow upper bits are visible on the indicators
    assign o_heartbeat = heartbeat_cnt[`HEARTBEAT_WIDTH-1 -: 4];

endmodule

`default_nettype wire

// File: tests/tb_stream_shell.sv
// Testbench for the stream shell covering both stream stages, the timer and the heartbeat
`timescale 1ns/1ps
`default_nettype none

`include "stream_shell_settings.svh"

module tb_stream_shell;

    localparam int          MAX_RECORDS = 32;
    localparam int          STALL_LIMIT = 64;
    localparam logic [31:0] LFSR_SEED   = 32'h64991775;

    logic                          sys_pll_clk;
    logic                          global_pll_resetn;
    logic [`STREAM_DATA_WIDTH-1:0] i_dma_in_data;
    logic                          i_dma_in_valid;
    logic                          o_dma_in_ready;
    logic [`STREAM_DATA_WIDTH-1:0] o_core_in_data;
    logic                          o_core_in_valid;
    logic                          i_core_in_ready;
    logic [`STREAM_DATA_WIDTH-1:0] i_core_out_data;
    logic [`STREAM_STRB_WIDTH-1:0] i_core_out_strb;
    logic                          i_core_out_valid;
    logic                          o_core_out_ready;
    logic [`STREAM_DATA_WIDTH-1:0] o_dma_out_data;
    logic                          o_dma_out_valid;
    logic                          i_dma_out_ready;
    logic                          i_timer_write;
    logic [`HW_TIMER_WIDTH-1:0]    i_timer_writedata;
    logic                          i_timer_read;
    logic [`HW_TIMER_WIDTH-1:0]    o_timer_readdata;
    logic                          o_timer_readdatavalid;
    logic [3:0]                    o_heartbeat;

    logic [`STREAM_DATA_WIDTH-1:0] stim_mem [0:MAX_RECORDS*4-1];
    logic [`STREAM_DATA_WIDTH-1:0] ing_data [$];
    logic [`STREAM_DATA_WIDTH-1:0] ing_exp [$];
    logic [`STREAM_DATA_WIDTH-1:0] eg_data [$];
    logic [`STREAM_STRB_WIDTH-1:0] eg_strb [$];
    logic [`STREAM_DATA_WIDTH-1:0] eg_exp [$];
    logic [31:0]                   lfsr_state;
    logic                          read_seen;

    stream_shell_top dut0 (.*);

    always #5 sys_pll_clk = ~sys_pll_clk;

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "Timeout");
    endtask

    // Taps 32, 22, 2 and 1, one step per bit
    function automatic logic [7:0] take_bits(input int count);
        logic [7:0] bits;
        logic       feedback;
        int         i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            bits       = {bits[6:0], feedback};
        end
        return bits;
    endfunction

    // Each record is four words for kind, input beat, strobe and expected beat
    task automatic load_records();
        int rec;
        for (rec = 0; rec < MAX_RECORDS*4; rec++) begin
            stim_mem[rec] = rec;
        end
        $readmemh("tests/stream_stimulus.dat", stim_mem);
        for (rec = 0; rec < MAX_RECORDS; rec++) begin
            if (stim_mem[rec*4] == 1) begin
                ing_data.push_back(stim_mem[rec*4+1]);
                ing_exp.push_back(stim_mem[rec*4+3]);
            end else if (stim_mem[rec*4] == 2) begin
                eg_data.push_back(stim_mem[rec*4+1]);
                eg_strb.push_back(stim_mem[rec*4+2][`STREAM_STRB_WIDTH-1:0]);
                eg_exp.push_back(stim_mem[rec*4+3]);
            end else begin
                break;
            end
        end
        if (ing_data.size() == 0 || eg_data.size() == 0) begin
            $display("The stimulus file held no ingress or no egress records");
            $display("CHECKS FAILED");
            $fatal(1, "Missing stimulus");
        end
    endtask

    task automatic run_ingress();
        int   sent;
        int   got;
        int   idle;
        logic accepted;
        sent = 0;
        got  = 0;
        idle = 0;
        while (got < ing_exp.size()) begin
            @(posedge sys_pll_clk);
            accepted = i_dma_in_valid && o_dma_in_ready;
            if (accepted) begin
                sent++;
            end
            if (o_core_in_valid && i_core_in_ready) begin
                check_value(o_core_in_data, ing_exp[got], "ingress beat byte order");
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > STALL_LIMIT) begin
                report_timeout("an ingress beat never reached the core side");
            end
            #1;
            // Core stalls about one cycle in four
            i_core_in_ready = (take_bits(2) != 8'd0);
            if (accepted || !i_dma_in_valid) begin
                i_dma_in_valid = 1'b0;
                if (sent < ing_data.size() && take_bits(2) != 8'd0) begin
                    i_dma_in_data  = ing_data[sent];
                    i_dma_in_valid = 1'b1;
                end
            end
        end
    endtask

    task automatic run_egress();
        int   sent;
        int   got;
        int   idle;
        logic accepted;
        sent = 0;
        got  = 0;
        idle = 0;
        while (got < eg_exp.size()) begin
            @(posedge sys_pll_clk);
            accepted = i_core_out_valid && o_core_out_ready;
            if (accepted) begin
                sent++;
            end
            if (o_dma_out_valid && i_dma_out_ready) begin
                check_value(o_dma_out_data, eg_exp[got], "egress beat masking");
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > STALL_LIMIT) begin
                report_timeout("an egress beat never reached the DMA side");
            end
            #1;
            i_dma_out_ready = (take_bits(2) != 8'd0);
            if (accepted || !i_core_out_valid) begin
                i_core_out_valid = 1'b0;
                if (sent < eg_data.size() && take_bits(2) != 8'd0) begin
                    i_core_out_data  = eg_data[sent];
                    i_core_out_strb  = eg_strb[sent];
                    i_core_out_valid = 1'b1;
                end
            end
        end
    endtask

    // Indicator bits follow counter bits 6 to 3
    task automatic watch_heartbeat();
        int         cyc;
        int         since;
        logic [3:0] prev;
        prev  = o_heartbeat;
        since = 0;
        for (cyc = 1; cyc <= 96; cyc++) begin
            @(posedge sys_pll_clk);
            if (o_heartbeat != prev) begin
                since = 0;
            end else begin
                since++;
            end
            prev = o_heartbeat;
            if (cyc == 9) begin
                check_value(o_heartbeat != 4'd0, 1'b1, "heartbeat moved 8 cycles after reset");
            end
            if (cyc > 9) begin
                check_value(since < 8, 1'b1, "heartbeat changed within 8 cycles");
            end
        end
        #1;
    endtask

    task automatic timer_write(input logic [31:0] value);
        i_timer_write     = 1'b1;
        i_timer_writedata = value;
        @(posedge sys_pll_clk);
        #1;
        i_timer_write     = 1'b0;
        i_timer_writedata = '0;
    endtask

    task automatic timer_read(output logic [31:0] value);
        int waited;
        i_timer_read = 1'b1;
        @(posedge sys_pll_clk);
        #1;
        i_timer_read = 1'b0;
        waited = 0;
        do begin
            @(posedge sys_pll_clk);
            waited++;
        end while (!o_timer_readdatavalid && waited < 8);
        if (!o_timer_readdatavalid) begin
            report_timeout("a timer read got no response");
        end
        value = o_timer_readdata;
        #1;
    endtask

    // Held count is the stop edge minus the start edge minus one
    task automatic measure_timer(input logic [31:0] stop_word);
        int          gap;
        int          edges;
        logic [31:0] first;
        logic [31:0] second;
        gap = 2 + take_bits(5);
        timer_write(32'h1);
        edges = 0;
        repeat (gap) begin
            @(posedge sys_pll_clk);
            edges++;
        end
        #1;
        timer_write(stop_word);
        edges++;
        repeat (2) @(posedge sys_pll_clk);
        #1;
        timer_read(first);
        check_value(first, edges - 1, "timer count after stop");
        repeat (take_bits(4) + 4) @(posedge sys_pll_clk);
        #1;
        timer_read(second);
        check_value(second, edges - 1, "timer count on a later read");
    endtask

    // Read valid must follow each read by exactly one cycle
    always @(posedge sys_pll_clk) begin
        if (global_pll_resetn) begin
            check_value(o_timer_readdatavalid, read_seen, "read data valid timing");
        end
        read_seen <= global_pll_resetn && i_timer_read;
    end

    initial begin
        logic [31:0] reset_count;
        sys_pll_clk       = 1'b0;
        global_pll_resetn = 1'b0;
        i_dma_in_data     = '0;
        i_dma_in_valid    = 1'b0;
        i_core_in_ready   = 1'b0;
        i_core_out_data   = '0;
        i_core_out_strb   = '0;
        i_core_out_valid  = 1'b0;
        i_dma_out_ready   = 1'b0;
        i_timer_write     = 1'b0;
        i_timer_writedata = '0;
        i_timer_read      = 1'b0;
        lfsr_state        = LFSR_SEED;
        load_records();

        repeat (4) @(posedge sys_pll_clk);
        check_value(o_core_in_valid, 1'b0, "core valid in reset");
        check_value(o_dma_out_valid, 1'b0, "DMA valid in reset");
        check_value(o_timer_readdatavalid, 1'b0, "read valid in reset");
        check_value(o_dma_in_ready, 1'b1, "DMA ready in reset");
        check_value(o_core_out_ready, 1'b1, "core ready in reset");
        check_value(o_heartbeat, 4'd0, "heartbeat in reset");
        #1;
        global_pll_resetn = 1'b1;

        fork
            run_ingress();
            run_egress();
            watch_heartbeat();
        join

        // Both stages must be empty once every beat has left
        i_core_in_ready = 1'b1;
        i_dma_out_ready = 1'b1;
        repeat (3) @(posedge sys_pll_clk);
        check_value(o_core_in_valid, 1'b0, "no extra ingress beat");
        check_value(o_dma_out_valid, 1'b0, "no extra egress beat");
        #1;

        timer_read(reset_count);
        check_value(reset_count, 32'd0, "timer count after reset");
        measure_timer(32'h2);
        measure_timer(32'h3);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/stream_stimulus.dat
// Columns: kind (1 ingress, 2 egress), input beat, strobe, expected output beat
// Strobe bit i covers byte i, byte 0 is the rightmost pair of digits
1 000102030405060708090a0b0c0d0e0f 0000 0f0e0d0c0b0a09080706050403020100
1 112233445566778899aabbccddeeff00 0000 00ffeeddccbbaa998877665544332211
1 deadbeef0123456789abcdeffedcba98 0000 98badcfeefcdab8967452301efbeadde
1 00000000000000000000000000000001 0000 01000000000000000000000000000000
1 a5a5a5a5000000005a5a5a5affffffff 0000 ffffffff5a5a5a5a00000000a5a5a5a5
1 0123456789abcdef0011223344556677 0000 7766554433221100efcdab8967452301
2 000102030405060708090a0b0c0d0e0f ffff 000102030405060708090a0b0c0d0e0f
2 000102030405060708090a0b0c0d0e0f 0000 ffffffffffffffffffffffffffffffff
2 112233445566778899aabbccddeeff00 00ff ffffffffffffffff99aabbccddeeff00
2 0123456789abcdef0011223344556677 ff00 0123456789abcdefffffffffffffffff
2 000102030405060708090a0b0c0d0e0f 5555 ff01ff03ff05ff07ff09ff0bff0dff0f
2 deadbeef0123456789abcdeffedcba98 8001 deffffffffffffffffffffffffffff98

// File: sources.f
+incdir+rtl
rtl/stream_types_pkg.sv
rtl/timer_types_pkg.sv
rtl/ingress_byte_swap.sv
rtl/egress_strobe_mask.sv
rtl/hw_timer_regs.sv
rtl/hw_timer_counter.sv
rtl/stream_shell_top.sv
tests/tb_stream_shell.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the stream shell testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_stream_shell -f sources.f

# The simulator exits non-zero on a failed check, the log decides the result
./obj_dir/Vtb_stream_shell > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
